// File: sources.f
rtl/rv_pkg.sv
rtl/rv_ifs.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_core.sv
tests/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the rv_core testbench with Verilator.
# All paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module rv_core_tb -Mdir "$OBJ" -o Vrv_core_tb
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator build failed"
    exit 1
fi

"./$OBJ/Vrv_core_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "ERROR: simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

// File: tests/rv_golden_trace.txt
# name pc inst retire_we rd data next_pc illegal ebreak mem_req mem_we mem_addr
# pc, inst, data, next_pc and mem_addr are hex; the flags and rd are decimal
lui_x1        00000100 123450b7 1  1 12345000 00000104 0 0 0 0 00000000
auipc_x2      00000104 00001117 1  2 00001104 00000108 0 0 0 0 00000000
addi_neg      00000108 ffb00193 1  3 fffffffb 0000010c 0 0 0 0 00000000
addi_ex_byp   0000010c 00718213 1  4 00000002 00000110 0 0 0 0 00000000
add_both_byp  00000110 004182b3 1  5 fffffffd 00000114 0 0 0 0 00000000
sub           00000114 40208333 1  6 12343efc 00000118 0 0 0 0 00000000
slli          00000118 00421393 1  7 00000020 0000011c 0 0 0 0 00000000
srai          0000011c 4011d413 1  8 fffffffd 00000120 0 0 0 0 00000000
srli          00000120 01c1d493 1  9 0000000f 00000124 0 0 0 0 00000000
slt           00000124 0041a533 1 10 00000001 00000128 0 0 0 0 00000000
sltu          00000128 0041b5b3 1 11 00000000 0000012c 0 0 0 0 00000000
xori          0000012c fff0c613 1 12 edcbafff 00000130 0 0 0 0 00000000
addi_to_x0    00000130 00108013 1  0 12345001 00000134 0 0 0 0 00000000
add_x0_read   00000134 001006b3 1 13 12345000 00000138 0 0 0 0 00000000
or            00000138 0043e733 1 14 00000022 0000013c 0 0 0 0 00000000
mul           0000013c 024187b3 1 15 fffffff6 00000140 0 0 0 0 00000000
mulh          00000140 02319833 1 16 00000000 00000144 0 0 0 0 00000000
mulhsu        00000144 0231a8b3 1 17 fffffffb 00000148 0 0 0 0 00000000
mulhu         00000148 0231b933 1 18 fffffff6 0000014c 0 0 0 0 00000000
div           0000014c 0241c9b3 1 19 fffffffe 00000150 0 0 0 0 00000000
divu          00000150 0241da33 1 20 7ffffffd 00000154 0 0 0 0 00000000
rem           00000154 0241eab3 1 21 ffffffff 00000158 0 0 0 0 00000000
remu          00000158 0241fb33 1 22 00000001 0000015c 0 0 0 0 00000000
div_by_zero   0000015c 0200cbb3 1 23 ffffffff 00000160 0 0 0 0 00000000
rem_by_zero   00000160 0200ec33 1 24 12345000 00000164 0 0 0 0 00000000
lui_min_int   00000164 80000cb7 1 25 80000000 00000168 0 0 0 0 00000000
addi_minus1   00000168 fff00d13 1 26 ffffffff 0000016c 0 0 0 0 00000000
div_overflow  0000016c 03accdb3 1 27 80000000 00000170 0 0 0 0 00000000
rem_overflow  00000170 03acee33 1 28 00000000 00000174 0 0 0 0 00000000
jal           00000174 010000ef 1  1 00000178 00000184 0 0 0 0 00000000
jalr_odd      00000184 009082e7 1  5 00000188 00000180 0 0 0 0 00000000
beq_taken     00000180 00318463 0  0 00000000 00000188 0 0 0 0 00000000
bne_not_taken 00000188 00319463 0  0 00000000 0000018c 0 0 0 0 00000000
blt_backward  0000018c fe41cae3 0  0 00000000 00000180 0 0 0 0 00000000
bgeu_not      00000180 00327463 0  0 00000000 00000184 0 0 0 0 00000000
lw            00000184 0100ae83 0  0 00000000 00000188 0 0 1 0 00000188
lbu           00000188 fff3cf03 0  0 00000000 0000018c 0 0 1 0 0000001f
sw            0000018c 00612423 0  0 00000000 00000190 0 0 1 1 0000110c
bad_op_f7     00000190 40209333 0  0 00000000 00000194 1 0 0 0 00000000
bad_slli_f7   00000194 40121393 0  0 00000000 00000198 1 0 0 0 00000000
bad_opcode    00000198 0000000b 0  0 00000000 0000019c 1 0 0 0 00000000
ebreak        0000019c 00100073 0  0 00000000 000001a0 0 1 0 0 00000000
ecall         000001a0 00000073 0  0 00000000 000001a4 1 0 0 0 00000000

// File: tests/rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
    localparam int RETIRE_TIMEOUT = 20;
    localparam string GOLDEN_FILE = "tests/rv_golden_trace.txt";

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic [XLEN-1:0]       next_pc;
        logic                  illegal;
        logic                  ebreak;
        logic                  mem_req;
        logic                  mem_we;
        logic [XLEN-1:0]       mem_addr;
    } vector_t;

    logic                  clk;
    logic                  arst_n;
    logic                  inst_valid;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       inst_pc;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_pc;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic                  retire_we;
    logic [XLEN-1:0]       retire_data;
    logic [XLEN-1:0]       retire_next_pc;
    logic                  retire_illegal;
    logic                  retire_ebreak;
    logic                  mem_req;
    logic                  mem_we;
    logic [FUNCT3_W-1:0]   mem_funct3;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       mem_wdata;

    vector_t vectors[$];
    string   names[$];
    int      issue_q[$];                                            // Drive cycle per instruction
    int      cycle_cnt = 0;
    int      test_errs = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;

    logic [XLEN-1:0] ref_regs[32];                                  // Register state from golden writes

    rv_core #(
        .RESET_PC (RESET_PC)
    ) rv_core_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_we      (retire_we),
        .retire_data    (retire_data),
        .retire_next_pc (retire_next_pc),
        .retire_illegal (retire_illegal),
        .retire_ebreak  (retire_ebreak),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_funct3     (mem_funct3),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic compare_field(input string test, input string field,
                                 input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test, field, expected, actual);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string test);
        if (test_errs == 0) begin
            $display("PASS %s", test);
            tests_passed++;
        end else begin
            $display("FAIL %s", test);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic load_golden();
        int              fd;
        int              cnt;
        int              we;
        int              rd;
        int              ill;
        int              ebr;
        int              mreq;
        int              mwe;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] npc;
        logic [XLEN-1:0] maddr;
        string           line;
        string           name;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            tests_failed++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%s %h %h %d %d %h %h %d %d %d %d %h", name, pc, word,
                          we, rd, data, npc, ill, ebr, mreq, mwe, maddr);
            if (cnt != 12) begin
                $display("Malformed line in the golden file: %s", line);
                tests_failed++;
                continue;
            end
            names.push_back(name);
            vectors.push_back({pc, word, we[0], rd[REG_ADDR_W-1:0], data, npc,
                               ill[0], ebr[0], mreq[0], mwe[0], maddr});
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic check_idle_after_reset(input string test);
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            compare_field(test, "retire_valid", '0, retire_valid);
            compare_field(test, "retire_we", '0, retire_we);
            compare_field(test, "mem_req", '0, mem_req);
            compare_field(test, "retire_next_pc", RESET_PC, retire_next_pc);
        end
        finish_test(test);
    endtask

    // Gaps carry random junk on inst while inst_valid is low
    task automatic drive_trace(input bit with_gaps);
        int gap;
        for (int i = 0; i < vectors.size(); i++) begin
            gap = with_gaps ? $urandom_range(3) : 0;
            repeat (gap) begin
                @(negedge clk);
                inst_valid = 1'b0;
                inst       = $urandom();
            end
            @(negedge clk);
            inst_valid = 1'b1;
            inst       = vectors[i].inst;
            inst_pc    = vectors[i].pc;
            issue_q.push_back(cycle_cnt);
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic check_retire(input string phase, input int idx, input int issue);
        vector_t v;
        string   test;
        v    = vectors[idx];
        test = {phase, ":", names[idx]};
        compare_field(test, "latency", issue + 3, cycle_cnt);      // Sample edge plus two
        compare_field(test, "retire_pc", v.pc, retire_pc);
        compare_field(test, "retire_we", v.we, retire_we);
        if (v.we) begin
            compare_field(test, "retire_rd", v.rd, retire_rd);
            compare_field(test, "retire_data", v.data, retire_data);
        end
        compare_field(test, "retire_next_pc", v.next_pc, retire_next_pc);
        compare_field(test, "retire_illegal", v.illegal, retire_illegal);
        compare_field(test, "retire_ebreak", v.ebreak, retire_ebreak);
        compare_field(test, "mem_req", v.mem_req, mem_req);
        if (v.mem_req) begin
            compare_field(test, "mem_we", v.mem_we, mem_we);
            compare_field(test, "mem_addr", v.mem_addr, mem_addr);
            compare_field(test, "mem_funct3", v.inst[14:12], mem_funct3);
            if (v.mem_we) begin
                compare_field(test, "mem_wdata", ref_regs[v.inst[24:20]], mem_wdata);
            end
        end
        if (v.we && v.rd != '0) begin
            ref_regs[v.rd] = v.data;
        end
        finish_test(test);
    endtask

    task automatic monitor_retires(input string phase);
        int waited;
        foreach (ref_regs[r]) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < vectors.size(); i++) begin
            waited = 0;
            @(negedge clk);
            while (!retire_valid && waited < RETIRE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!retire_valid) begin
                $display("Timeout in phase %s: %s did not retire within %0d cycles",
                         phase, names[i], RETIRE_TIMEOUT);
                tests_failed++;
                return;
            end
            check_retire(phase, i, issue_q.pop_front());
        end
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        void'($urandom(32'h802b));
        load_golden();

        apply_reset();
        check_idle_after_reset("reset_state");
        issue_q.delete();
        fork
            drive_trace(1'b0);
            monitor_retires("b2b");
        join

        // Same trace again from a clean register file, with idle gaps
        @(negedge clk);
        apply_reset();
        check_idle_after_reset("reset_again");
        issue_q.delete();
        fork
            drive_trace(1'b1);
            monitor_retires("gaps");
        join

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && vectors.size() > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: rtl/rv_core.sv
module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  logic [XLEN-1:0]       inst,
    input  logic [XLEN-1:0]       inst_pc,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic                  retire_we,
    output logic [XLEN-1:0]       retire_data,
    output logic [XLEN-1:0]       retire_next_pc,
    output logic                  retire_illegal,
    output logic                  retire_ebreak,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [FUNCT3_W-1:0]   mem_funct3,
    output logic [XLEN-1:0]       mem_addr,
    output logic [XLEN-1:0]       mem_wdata
);

    logic [REG_ADDR_W-1:0] rf_rs1_addr;
    logic [REG_ADDR_W-1:0] rf_rs2_addr;
    logic [XLEN-1:0]       rf_rs1_data;
    logic [XLEN-1:0]       rf_rs2_data;

    dec_bus_if dec_bus ();
    wb_bus_if  wb_bus ();

    decode_stage decode_stage_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .rs_bypass   (wb_bus.bypass),
        .rf_rs1_addr (rf_rs1_addr),
        .rf_rs2_addr (rf_rs2_addr),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .dec         (dec_bus.producer)
    );

    execute_stage #(
        .RESET_PC (RESET_PC)
    ) execute_stage_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .dec            (dec_bus.consumer),
        .wb             (wb_bus.source),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_we      (retire_we),
        .retire_data    (retire_data),
        .retire_next_pc (retire_next_pc),
        .retire_illegal (retire_illegal),
        .retire_ebreak  (retire_ebreak),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_funct3     (mem_funct3),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb       (wb_bus.sink),
        .rs1_addr (rf_rs1_addr),
        .rs2_addr (rf_rs2_addr),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

endmodule

// File: rtl/execute_stage.sv
module execute_stage import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    dec_bus_if.consumer           dec,
    wb_bus_if.source              wb,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic                  retire_we,
    output logic [XLEN-1:0]       retire_data,
    output logic [XLEN-1:0]       retire_next_pc,
    output logic                  retire_illegal,
    output logic                  retire_ebreak,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [FUNCT3_W-1:0]   mem_funct3,
    output logic [XLEN-1:0]       mem_addr,
    output logic [XLEN-1:0]       mem_wdata
);

    logic [XLEN-1:0]          pc_plus4;
    logic [XLEN-1:0]          pc_plus_imm;
    logic [XLEN-1:0]          rs1_plus_imm;
    logic [XLEN-1:0]          alu_b;
    logic                     alt_op;
    logic [XLEN-1:0]          alu_res;
    logic                     mul_sa;
    logic                     mul_sb;
    logic signed [2*XLEN+1:0] product;
    logic                     div_zero;
    logic                     div_ovf;
    logic [XLEN-1:0]          md_res;
    logic [XLEN-1:0]          result;
    logic                     br_taken;
    logic [XLEN-1:0]          next_pc;

    assign pc_plus4     = dec.pc + 32'd4;
    assign pc_plus_imm  = dec.pc + dec.imm;
    assign rs1_plus_imm = dec.rs1_val + dec.imm;

    assign alu_b  = (dec.op_class == OP) ? dec.rs2_val : dec.imm;
    assign alt_op = dec.funct7[5];                                  // SUB and SRA select

    always_comb begin
        case (dec.funct3)
            3'b000: begin
                if (dec.op_class == OP && alt_op) alu_res = dec.rs1_val - alu_b;
                else alu_res = dec.rs1_val + alu_b;
            end
            3'b001: alu_res = dec.rs1_val << alu_b[4:0];
            3'b010: alu_res = {31'b0, $signed(dec.rs1_val) < $signed(alu_b)};
            3'b011: alu_res = {31'b0, dec.rs1_val < alu_b};
            3'b100: alu_res = dec.rs1_val ^ alu_b;
            3'b101: begin
                if (alt_op) alu_res = $signed(dec.rs1_val) >>> alu_b[4:0];
                else alu_res = dec.rs1_val >> alu_b[4:0];
            end
            3'b110: alu_res = dec.rs1_val | alu_b;
            default: alu_res = dec.rs1_val & alu_b;
        endcase
    end

    // One 33x33 signed multiplier covers all four products
    assign mul_sa  = (dec.funct3 == 3'b001) || (dec.funct3 == 3'b010);
    assign mul_sb  = (dec.funct3 == 3'b001);
    assign product = $signed({mul_sa & dec.rs1_val[XLEN-1], dec.rs1_val})
                   * $signed({mul_sb & dec.rs2_val[XLEN-1], dec.rs2_val});

    assign div_zero = (dec.rs2_val == '0);
    assign div_ovf  = (dec.rs1_val == {1'b1, {(XLEN-1){1'b0}}}) && (dec.rs2_val == '1);

    always_comb begin
        md_res = product[XLEN-1:0];
        case (dec.funct3)
            3'b001, 3'b010, 3'b011: md_res = product[2*XLEN-1:XLEN];
            3'b100: begin
                if (div_zero) md_res = '1;
                else if (div_ovf) md_res = dec.rs1_val;
                else md_res = $signed(dec.rs1_val) / $signed(dec.rs2_val);
            end
            3'b101: md_res = div_zero ? '1 : dec.rs1_val / dec.rs2_val;
            3'b110: begin
                if (div_zero) md_res = dec.rs1_val;
                else if (div_ovf) md_res = '0;
                else md_res = $signed(dec.rs1_val) % $signed(dec.rs2_val);
            end
            3'b111: md_res = div_zero ? dec.rs1_val : dec.rs1_val % dec.rs2_val;
            default: md_res = product[XLEN-1:0];                   // MUL
        endcase
    end

    always_comb begin
        case (dec.op_class)
            LUI:       result = dec.imm;
            AUIPC:     result = pc_plus_imm;
            JAL, JALR: result = pc_plus4;                           // Link address
            MULDIV:    result = md_res;
            default:   result = alu_res;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  br_taken = (dec.rs1_val == dec.rs2_val);
            3'b001:  br_taken = (dec.rs1_val != dec.rs2_val);
            3'b100:  br_taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
            3'b101:  br_taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
            3'b110:  br_taken = (dec.rs1_val < dec.rs2_val);
            3'b111:  br_taken = (dec.rs1_val >= dec.rs2_val);
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op_class)
            JAL:     next_pc = pc_plus_imm;
            JALR:    next_pc = {rs1_plus_imm[XLEN-1:1], 1'b0};
            BRANCH:  next_pc = br_taken ? pc_plus_imm : pc_plus4;
            default: next_pc = pc_plus4;                            // Also ILLEGAL
        endcase
    end

    assign wb.ex_we      = dec.valid && dec.reg_write_en;
    assign wb.ex_rd_addr = dec.rd_addr;
    assign wb.ex_data    = result;
    assign wb.we         = retire_we;
    assign wb.rd_addr    = retire_rd;
    assign wb.data       = retire_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid   <= 1'b0;
            retire_we      <= 1'b0;
            retire_illegal <= 1'b0;
            retire_ebreak  <= 1'b0;
            mem_req        <= 1'b0;
            mem_we         <= 1'b0;
            retire_next_pc <= RESET_PC;
        end else begin
            retire_valid   <= dec.valid;
            retire_we      <= dec.valid && dec.reg_write_en;
            retire_illegal <= dec.valid && (dec.op_class == ILLEGAL);
            retire_ebreak  <= dec.valid && (dec.op_class == EBREAK);
            mem_req        <= dec.valid && (dec.op_class inside {LOAD, STORE});
            mem_we         <= dec.valid && (dec.op_class == STORE);
            if (dec.valid) retire_next_pc <= next_pc;               // Holds between retires
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            retire_pc   <= dec.pc;
            retire_rd   <= dec.rd_addr;
            retire_data <= result;
            mem_funct3  <= dec.funct3;
            mem_addr    <= rs1_plus_imm;
            mem_wdata   <= dec.rs2_val;
        end
    end

endmodule

// File: rtl/decode_stage.sv
module decode_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  logic [XLEN-1:0]       inst,
    input  logic [XLEN-1:0]       inst_pc,
    wb_bus_if.bypass              rs_bypass,
    output logic [REG_ADDR_W-1:0] rf_rs1_addr,
    output logic [REG_ADDR_W-1:0] rf_rs2_addr,
    input  logic [XLEN-1:0]       rf_rs1_data,
    input  logic [XLEN-1:0]       rf_rs2_data,
    dec_bus_if.producer           dec
);

    logic                in_valid;
    logic [XLEN-1:0]     in_inst;
    logic [XLEN-1:0]     in_pc;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_b;
    logic [XLEN-1:0]     imm_u;
    logic [XLEN-1:0]     imm_j;
    logic [XLEN-1:0]     imm;
    op_class_e           op_class;
    logic                reg_write_en;
    logic [XLEN-1:0]     rs1_val;
    logic [XLEN-1:0]     rs2_val;

    function automatic logic [XLEN-1:0] read_operand(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_data
    );
        if (addr == '0) return '0;
        if (rs_bypass.ex_we && rs_bypass.ex_rd_addr == addr) return rs_bypass.ex_data;
        return rf_data;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            in_inst <= inst;
            in_pc   <= inst_pc;
        end
    end

    assign opcode = in_inst[6:0];
    assign funct3 = in_inst[14:12];
    assign funct7 = in_inst[31:25];

    assign imm_i = {{20{in_inst[31]}}, in_inst[31:20]};
    assign imm_s = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
    assign imm_b = {{19{in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
                    in_inst[11:8], 1'b0};
    assign imm_u = {in_inst[31:12], 12'b0};
    assign imm_j = {{11{in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
                    in_inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_STORE:          imm = imm_s;
            OPC_BRANCH:         imm = imm_b;
            OPC_LUI, OPC_AUIPC: imm = imm_u;
            OPC_JAL:            imm = imm_j;
            default:            imm = imm_i;
        endcase
    end

    // Anything not matched below stays ILLEGAL
    always_comb begin
        op_class = ILLEGAL;
        case (opcode)
            OPC_LUI:    op_class = LUI;
            OPC_AUIPC:  op_class = AUIPC;
            OPC_JAL:    op_class = JAL;
            OPC_JALR:   if (funct3 == 3'b000) op_class = JALR;
            OPC_LOAD:   if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
                            op_class = LOAD;
            OPC_STORE:  if (funct3 inside {3'b000, 3'b001, 3'b010}) op_class = STORE;
            OPC_BRANCH: if (!(funct3 inside {3'b010, 3'b011})) op_class = BRANCH;
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    if (funct7 == 7'b0000000) op_class = OP_IMM;            // SLLI
                end else if (funct3 == 3'b101) begin
                    if (funct7 inside {7'b0000000, 7'b0100000}) op_class = OP_IMM;
                end else begin
                    op_class = OP_IMM;
                end
            end
            OPC_OP: begin
                if (funct7 == 7'b0000001) begin
                    op_class = MULDIV;
                end else if (funct7 == 7'b0000000) begin
                    op_class = OP;
                end else if (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}) begin
                    op_class = OP;                                          // SUB, SRA
                end
            end
            OPC_SYSTEM: if (funct3 == 3'b000 && imm_i == 32'd1) op_class = EBREAK;
            default:    op_class = ILLEGAL;
        endcase
    end

    assign reg_write_en = op_class inside {LUI, AUIPC, JAL, JALR, OP_IMM, OP, MULDIV};

    assign rf_rs1_addr = in_inst[19:15];
    assign rf_rs2_addr = in_inst[24:20];

    assign rs1_val = read_operand(rf_rs1_addr, rf_rs1_data);
    assign rs2_val = read_operand(rf_rs2_addr, rf_rs2_data);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec.pc           <= in_pc;
            dec.op_class     <= op_class;
            dec.funct3       <= funct3;
            dec.funct7       <= funct7;
            dec.rs1_val      <= rs1_val;
            dec.rs2_val      <= rs2_val;
            dec.imm          <= imm;
            dec.rd_addr      <= in_inst[11:7];
            dec.reg_write_en <= reg_write_en;
        end
    end

endmodule

// File: rtl/reg_file.sv
module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    wb_bus_if.sink                wb,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];                     // No storage for x0

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) return '0;
        if (wb.we && wb.rd_addr == addr) return wb.data;           // Write-through
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd_addr != '0) begin
            regs[wb.rd_addr] <= wb.data;
        end
    end

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

endmodule

// File: rtl/rv_ifs.sv
interface dec_bus_if import rv_pkg::*; ();

    logic                  valid;        // One-cycle strobe
    logic [XLEN-1:0]       pc;
    op_class_e             op_class;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  reg_write_en;

    modport producer (
        output valid, pc, op_class, funct3, funct7,
        output rs1_val, rs2_val, imm, rd_addr, reg_write_en
    );

    modport consumer (
        input valid, pc, op_class, funct3, funct7,
        input rs1_val, rs2_val, imm, rd_addr, reg_write_en
    );

endinterface

interface wb_bus_if import rv_pkg::*; ();

    logic                  we;           // Registered retire write
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       data;
    logic                  ex_we;        // Execute result, one stage early
    logic [REG_ADDR_W-1:0] ex_rd_addr;
    logic [XLEN-1:0]       ex_data;

    modport source (
        output we, rd_addr, data,
        output ex_we, ex_rd_addr, ex_data
    );

    modport sink (input we, rd_addr, data);

    modport bypass (input ex_we, ex_rd_addr, ex_data);

endinterface

// File: rtl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int OPCODE_W   = 7;

    // Base opcodes, inst[6:0]
    localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        LOAD,
        STORE,
        BRANCH,
        OP_IMM,
        OP,
        MULDIV,
        EBREAK,
        ILLEGAL
    } op_class_e;

endpackage
